// File: source/video_pkg.sv
// Shared raster geometry and vector types for the tile video path
// Raster is tiny on purpose, 48x32 visible inside 64x40 total
// Cell bytes are direct 3:3:2 RGB, zero is transparent
// Cell edge must be a power of two, the address is taken from counter bits
package video_pkg;

    // Horizontal raster in pixels
    localparam int h_total      = 64;
    localparam int h_active     = 48;
    localparam int h_sync_start = 52;  // Sync high for 52..55
    localparam int h_sync_end   = 56;

    // Vertical raster in lines
    localparam int v_total      = 40;
    localparam int v_active     = 32;
    localparam int v_sync_start = 34;  // Two sync lines
    localparam int v_sync_end   = 36;

    // Cell grid
    localparam int cell_size  = 8;
    localparam int cell_shift = $clog2(cell_size);  // Counter bits below the cell index
    localparam int cols       = h_active / cell_size;
    localparam int rows       = v_active / cell_size;
    localparam int cells      = rows * cols;        // RAM entries per layer

    // Layer count, index 0 wins
    localparam int num_layers = 2;

    typedef logic [$clog2(h_total)-1:0]    hcnt_t;
    typedef logic [$clog2(v_total)-1:0]    vcnt_t;
    typedef logic [$clog2(cells)-1:0]      cell_addr_t;  // row * cols + col
    typedef logic [7:0]                    color_t;      // R3 G3 B2
    typedef logic [$clog2(num_layers)-1:0] layer_sel_t;

endpackage

// File: source/video_timing.sv
// Raster timing for the tile layers and the mixer
// pxl_cen is clk divided by two, first pulse two cycles after reset
// Blanking and sync are registered and move with the counters
// wr_ready is simply the half of each pixel period with no RAM read
module video_timing
    import video_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  pxl_cen,
    output hcnt_t hcnt,
    output vcnt_t vcnt,
    output logic  hblank,
    output logic  vblank,
    output logic  hsync,
    output logic  vsync,
    output logic  wr_ready
);

    hcnt_t h_next;
    vcnt_t v_next;
    logic  line_end;
    logic  frame_end;

    assign line_end  = hcnt == hcnt_t'(h_total - 1);
    assign frame_end = vcnt == vcnt_t'(v_total - 1);

    // Next raster position, vertical only moves at line end
    always_comb begin
        h_next = line_end ? '0 : hcnt + 1'b1;
        v_next = vcnt;
        if (line_end) begin
            v_next = frame_end ? '0 : vcnt + 1'b1;
        end
    end

    // Pixel clock enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Counters plus decoded strobes, all on the same pxl_cen edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt   <= '0;
            vcnt   <= '0;
            hblank <= 1'b0;  // (0,0) is visible
            vblank <= 1'b0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else if (pxl_cen) begin
            hcnt   <= h_next;
            vcnt   <= v_next;
            // Decode from the next value so strobes line up with the counters
            hblank <= h_next >= hcnt_t'(h_active);
            vblank <= v_next >= vcnt_t'(v_active);
            hsync  <= (h_next >= hcnt_t'(h_sync_start)) &&
                      (h_next <  hcnt_t'(h_sync_end));
            vsync  <= (v_next >= vcnt_t'(v_sync_start)) &&
                      (v_next <  vcnt_t'(v_sync_end));
        end
    end

    // CPU slot while layers are idle
    // Never low for more than one clk
    assign wr_ready = ~pxl_cen;

endmodule

// File: source/tile_layer.sv
// One tile layer, a byte per 8x8 cell, byte is the RGB colour itself
// All layers share the write port, only layer_id == wr_layer stores
// Writes only land in the wr_ready half, reads only on pxl_cen
// so the RAM never sees both in the same cycle
// pix lags the counters by one pixel period
module tile_layer
    import video_pkg::*;
#(
    parameter int layer_id = 0  // 0 .. num_layers-1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  hcnt_t      hcnt,
    input  vcnt_t      vcnt,
    input  logic       wr_valid,
    input  logic       wr_ready,
    input  layer_sel_t wr_layer,
    input  cell_addr_t wr_addr,
    input  color_t     wr_data,
    output color_t     pix
);

    color_t     ram [cells];  // Cell colours
    logic       wr_en;
    logic       h_vis;
    logic       v_vis;
    logic       active;
    hcnt_t      col;
    vcnt_t      row;
    cell_addr_t rd_addr;

    // Handshake completes this edge and the byte is ours
    assign wr_en = wr_valid && wr_ready && (wr_layer == layer_sel_t'(layer_id));

    // Visible window
    assign h_vis  = hcnt < hcnt_t'(h_active);
    assign v_vis  = vcnt < vcnt_t'(v_active);
    assign active = h_vis && v_vis;

    // Cell index from bits above the cell edge
    assign col     = hcnt >> cell_shift;
    assign row     = vcnt >> cell_shift;
    assign rd_addr = cell_addr_t'(int'(row) * cols + int'(col));  // Only in range when active

    // Cell RAM, cleared to transparent in reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cells; i++) begin
                ram[i] <= '0;
            end
        end else if (wr_en) begin
            ram[wr_addr] <= wr_data;
        end
    end

    // Fetch for the position on the counters now
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else if (pxl_cen) begin
            if (active) begin
                pix <= ram[rd_addr];
            end else begin
                pix <= '0;  // Transparent outside the window
            end
        end
    end

endmodule

// File: source/color_mixer.sv
// Priority mixer for the tile layers, lowest index in front
// Layer pixels arrive one pixel period after the counters
// Blank and sync get a two stage delay to stay aligned with the colour
// Outputs come out of reset black and blanked
module color_mixer
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  color_t     layer_pix [num_layers],
    input  logic       hblank,
    input  logic       vblank,
    input  logic       hsync,
    input  logic       vsync,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue,
    output logic       blank,
    output logic       hsync_out,
    output logic       vsync_out
);

    color_t mix;
    color_t out_color;
    logic   blank_d1;  // Aligned with layer_pix
    logic   hsync_d1;
    logic   vsync_d1;

    // Walk from the back so layer 0 ends up on top
    always_comb begin
        mix = '0;  // Black if nothing opaque
        for (int i = num_layers - 1; i >= 0; i--) begin
            if (layer_pix[i] != '0) begin
                mix = layer_pix[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blank_d1  <= 1'b1;
            hsync_d1  <= 1'b0;
            vsync_d1  <= 1'b0;
            out_color <= '0;
            blank     <= 1'b1;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else if (pxl_cen) begin
            // First stage, matches the layer fetch
            blank_d1  <= hblank | vblank;
            hsync_d1  <= hsync;
            vsync_d1  <= vsync;
            // Second stage, matches the colour register
            out_color <= blank_d1 ? '0 : mix;
            blank     <= blank_d1;
            hsync_out <= hsync_d1;
            vsync_out <= vsync_d1;
        end
    end

    assign red   = out_color[7:5];
    assign green = out_color[4:2];
    assign blue  = out_color[1:0];

endmodule

// File: source/video_top.sv
// Tile video top, timing plus layers plus mixer
// RGB, blank and sync trail the raster counters by two pixel periods
// Writer must hold its fields while wr_valid is high and wr_ready low
module video_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_valid,
    input  layer_sel_t wr_layer,
    input  cell_addr_t wr_addr,
    input  color_t     wr_data,
    output logic       wr_ready,
    output logic       pxl_cen,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue,
    output logic       blank,
    output logic       hsync,
    output logic       vsync
);

    hcnt_t  hcnt;
    vcnt_t  vcnt;
    logic   hblank;
    logic   vblank;
    logic   raw_hsync;  // Counter aligned, before the mixer delay
    logic   raw_vsync;
    color_t layer_pix [num_layers];

    video_timing u_timing (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .pxl_cen  ( pxl_cen   ),
        .hcnt     ( hcnt      ),
        .vcnt     ( vcnt      ),
        .hblank   ( hblank    ),
        .vblank   ( vblank    ),
        .hsync    ( raw_hsync ),
        .vsync    ( raw_vsync ),
        .wr_ready ( wr_ready  )
    );

    // One layer per index, same write port to all
    for (genvar i = 0; i < num_layers; i++) begin : g_layer
        tile_layer #(
            .layer_id ( i )
        ) u_layer (
            .clk      ( clk          ),
            .rst_n    ( rst_n        ),
            .pxl_cen  ( pxl_cen      ),
            .hcnt     ( hcnt         ),
            .vcnt     ( vcnt         ),
            .wr_valid ( wr_valid     ),
            .wr_ready ( wr_ready     ),
            .wr_layer ( wr_layer     ),
            .wr_addr  ( wr_addr      ),
            .wr_data  ( wr_data      ),
            .pix      ( layer_pix[i] )
        );
    end

    color_mixer u_mixer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .layer_pix ( layer_pix ),
        .hblank    ( hblank    ),
        .vblank    ( vblank    ),
        .hsync     ( raw_hsync ),
        .vsync     ( raw_vsync ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .blank     ( blank     ),
        .hsync_out ( hsync     ),
        .vsync_out ( vsync     )
    );

endmodule

// File: tests/video_asserts.sv
// Concurrent checks on the write handshake and output blanking
// Bound into every video_top, sees only its ports
module video_asserts
    import video_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       wr_valid,
    input logic       wr_ready,
    input layer_sel_t wr_layer,
    input cell_addr_t wr_addr,
    input color_t     wr_data,
    input logic [2:0] red,
    input logic [2:0] green,
    input logic [1:0] blue,
    input logic       blank
);
    timeunit 1ns;
    timeprecision 1ps;

    // pxl_cen is low straight out of reset
    ready_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> wr_ready
    ) else $error("wr_ready low in the first cycle after reset");

    no_color_in_blank: assert property (
        @(posedge clk) disable iff (!rst_n)
        blank |-> ({red, green, blue} == 8'h00)
    ) else $error("colour output non-zero while blank is high");

    // Stalled write keeps its fields
    write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_valid && !wr_ready) |=>
            (wr_valid && $stable(wr_layer) && $stable(wr_addr) && $stable(wr_data))
    ) else $error("write dropped or changed while wr_ready was low");

endmodule

bind video_top video_asserts u_asserts (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .wr_valid ( wr_valid ),
    .wr_ready ( wr_ready ),
    .wr_layer ( wr_layer ),
    .wr_addr  ( wr_addr  ),
    .wr_data  ( wr_data  ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     ),
    .blank    ( blank    )
);

// File: tests/video_tb.sv
// Directed testbench for the tile video top
// Outputs sampled once per pixel, at the falling clk edge while pxl_cen is high
// Frame alignment comes only from the blank and vsync outputs
// Each frame capture costs up to two frames, three captures in all
module video_tb
    import video_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int seed_init      = 32'h15614bb2;
    localparam int frame_cycles   = h_total * v_total * 2;  // Two clk per pixel
    localparam int timeout_cycles = 6 * frame_cycles + 1000;
    localparam int bp_writes      = 6;  // Writes started against wr_ready low

    logic       clk;
    logic       rst_n;
    logic       wr_valid;
    layer_sel_t wr_layer;
    cell_addr_t wr_addr;
    color_t     wr_data;
    logic       wr_ready;
    logic       pxl_cen;
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;
    logic       blank;
    logic       hsync;
    logic       vsync;

    int     errors;
    int     checks;
    int     cycles;
    int     stall_cycles;  // Wait cycles of the last write
    int     seed;
    logic   last_cen;      // pxl_cen at the previous falling edge
    logic   cen_seen;      // last_cen was taken out of reset
    color_t model [num_layers][cells];   // Expected cell RAM contents
    color_t frame [v_active][h_active];  // Last captured visible area
    color_t s_color;
    logic   s_blank;
    logic   s_hs;
    logic   s_vs;

    video_top uut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .wr_valid ( wr_valid ),
        .wr_layer ( wr_layer ),
        .wr_addr  ( wr_addr  ),
        .wr_data  ( wr_data  ),
        .wr_ready ( wr_ready ),
        .pxl_cen  ( pxl_cen  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .blank    ( blank    ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    )
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // Pixel enable is high every second clk
    always @(negedge clk) begin
        if (rst_n && cen_seen) begin
            expect_true(pxl_cen != last_cen, "pxl_cen did not toggle");
        end
        last_cen = pxl_cen;
        cen_seen = rst_n;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timeout: run did not finish within %0d clock cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("** Error @ %0t: %s", $time, what);
        end
    endtask

    task automatic expect_color(input color_t got, input color_t exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error @ %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    // Called and returns at 2 ns after a rising edge
    task automatic cpu_write(input layer_sel_t layer, input cell_addr_t addr, input color_t data);
        logic taken;
        int   waits;
        taken    = 1'b0;
        waits    = 0;
        wr_valid = 1'b1;
        wr_layer = layer;
        wr_addr  = addr;
        wr_data  = data;
        while (!taken) begin
            @(negedge clk);
            taken = wr_ready;  // Stable mid cycle
            @(posedge clk);
            #2;
            if (!taken) begin
                waits++;
            end
        end
        wr_valid     = 1'b0;
        stall_cycles = waits;
        model[int'(layer)][int'(addr)] = data;
    endtask

    // One sample per pixel period
    task automatic sample_pixel;
        @(negedge clk);
        while (!pxl_cen) begin
            @(negedge clk);
        end
        s_color = {red, green, blue};
        s_blank = blank;
        s_hs    = hsync;
        s_vs    = vsync;
    endtask

    function automatic logic hsync_at(int x);
        return (x >= h_sync_start) && (x < h_sync_end);
    endfunction

    function automatic logic vsync_at(int y);
        return (y >= v_sync_start) && (y < v_sync_end);
    endfunction

    // First opaque layer from the front, black if none
    function automatic color_t expected_pixel(int x, int y);
        int     addr;
        color_t c;
        addr = (y / cell_size) * cols + (x / cell_size);
        c    = '0;
        for (int l = 0; l < num_layers; l++) begin
            if (c == '0) begin
                c = model[l][addr];
            end
        end
        return c;
    endfunction

    // Whole raster, checks blank and sync shape on every sample
    task automatic capture_frame;
        logic vis;
        sample_pixel();
        while (!s_vs) sample_pixel();
        while (s_vs) sample_pixel();
        while (s_blank) sample_pixel();  // Now at the first visible pixel
        for (int y = 0; y < v_total; y++) begin
            for (int x = 0; x < h_total; x++) begin
                if (x != 0 || y != 0) begin
                    sample_pixel();
                end
                vis = (x < h_active) && (y < v_active);
                expect_true(s_blank == !vis, $sformatf("blank wrong at (%0d,%0d)", x, y));
                expect_true(s_hs == hsync_at(x), $sformatf("hsync wrong at (%0d,%0d)", x, y));
                expect_true(s_vs == vsync_at(y), $sformatf("vsync wrong at (%0d,%0d)", x, y));
                if (vis) begin
                    frame[y][x] = s_color;
                end else begin
                    expect_color(s_color, 8'h00, $sformatf("blanked colour at (%0d,%0d)", x, y));
                end
            end
        end
        @(posedge clk);
        #2;  // Back on the stimulus grid
    endtask

    task automatic compare_frame(input string what);
        for (int y = 0; y < v_active; y++) begin
            for (int x = 0; x < h_active; x++) begin
                expect_color(frame[y][x], expected_pixel(x, y),
                             $sformatf("%s pixel (%0d,%0d)", what, x, y));
            end
        end
    endtask

    // All 64 pixels of one cell
    task automatic check_cell(input int addr, input color_t exp, input string what);
        int x0;
        int y0;
        x0 = (addr % cols) * cell_size;
        y0 = (addr / cols) * cell_size;
        for (int dy = 0; dy < cell_size; dy++) begin
            for (int dx = 0; dx < cell_size; dx++) begin
                expect_color(frame[y0 + dy][x0 + dx], exp,
                             $sformatf("%s cell %0d (%0d,%0d)", what, addr, dx, dy));
            end
        end
    endtask

    // Cleared RAMs, so black everywhere
    task automatic test_reset_frame;
        capture_frame();
        compare_frame("reset frame");
    endtask

    task automatic test_layer_rules;
        // Both layers opaque, layer 0 in front
        cpu_write(1'b0, 5'd0, 8'he0);
        cpu_write(1'b1, 5'd0, 8'h1c);
        cpu_write(1'b1, 5'd8, 8'h03);
        cpu_write(1'b0, 5'd8, 8'hff);
        cpu_write(1'b0, 5'd19, 8'h49);
        cpu_write(1'b1, 5'd19, 8'hb6);
        cpu_write(1'b1, 5'd4, 8'h1f);   // Layer 0 left clear
        cpu_write(1'b0, 5'd13, 8'h00);  // Explicit zero in front
        cpu_write(1'b1, 5'd13, 8'h92);
        cpu_write(1'b0, 5'd21, 8'h00);  // Both transparent
        cpu_write(1'b1, 5'd21, 8'h00);
        for (int i = 0; i < bp_writes; i++) begin
            while (wr_ready) begin
                @(posedge clk);
                #2;
            end
            cpu_write(layer_sel_t'(i % 2), cell_addr_t'(2 + i * 4), color_t'(8'h25 * (i + 1)));
            expect_true(stall_cycles == 1, "write against wr_ready low did not wait one cycle");
        end
        capture_frame();
        check_cell(0, 8'he0, "priority");
        check_cell(8, 8'hff, "priority");
        check_cell(19, 8'h49, "priority");
        check_cell(4, 8'h1f, "transparent front");
        check_cell(13, 8'h92, "transparent front");
        check_cell(21, 8'h00, "both transparent");
        compare_frame("layer rules");
    endtask

    task automatic test_random_fill;
        color_t data;
        for (int l = 0; l < num_layers; l++) begin
            for (int a = 0; a < cells; a++) begin
                data = color_t'($random(seed));
                if (($random(seed) & 3) == 0) begin
                    data = '0;  // About a quarter transparent
                end
                cpu_write(layer_sel_t'(l), cell_addr_t'(a), data);
            end
        end
        capture_frame();
        compare_frame("random fill");
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        stall_cycles = 0;
        last_cen     = 1'b0;
        cen_seen     = 1'b0;
        seed         = seed_init;
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr_layer     = '0;
        wr_addr      = '0;
        wr_data      = '0;
        for (int l = 0; l < num_layers; l++) begin
            for (int a = 0; a < cells; a++) begin
                model[l][a] = '0;
            end
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_frame();
        test_layer_rules();
        test_random_fill();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/video_pkg.sv
source/video_timing.sv
source/tile_layer.sv
source/color_mixer.sv
source/video_top.sv
tests/video_asserts.sv
tests/video_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the tile video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module video_tb -f files.f -o video_sim

# An aborted simulation counts as a failure
./obj_dir/video_sim > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
